// ==== common/gnss_sig_pkg.sv ====
package gnss_sig_pkg;

    typedef logic [31:0] word_t;       // host data word and memory word
    typedef logic [9:0]  code_addr_t;  // code chip index
    typedef logic [4:0]  code_waddr_t; // code memory word index
    typedef logic [8:0]  msg_addr_t;   // message bit index
    typedef logic [3:0]  msg_waddr_t;  // message memory word index
    typedef logic [7:0]  word_addr_t;  // control memory index
    typedef logic [9:0]  delay_t;      // code delay in chips
    typedef logic [4:0]  epoch_cnt_t;  // code periods inside one message bit

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_CARRIER,
        LD_CODE_FRE,
        LD_CODE_PHA,
        LD_DELAY
    } loader_state_t;

    localparam code_addr_t CODE_LEN       = 10'd1023; // largest value of the chip count
    localparam int         MSG_WORDS      = 10;
    localparam msg_addr_t  MSG_LOOP_START = 9'd20;    // first bit of the repeating part
    localparam msg_addr_t  MSG_LAST       = 9'd319;
    localparam epoch_cnt_t EPOCHS_PER_BIT = 5'd20;
    localparam int         LOAD_PERIOD    = 100;      // clocks between parameter reloads
    localparam int         WORDS_PER_LOAD = 4;

endpackage

// ==== source/load_timer.sv ====
`timescale 1ns/1ps

module load_timer (
    input  logic clk_1023k,
    input  logic rst_n,
    output logic load_tick
);
    import gnss_sig_pkg::*;

    logic [6:0] tick_cnt;

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt  <= '0;
            load_tick <= 1'b0;
        end else if (tick_cnt == 7'(LOAD_PERIOD - 1)) begin
            tick_cnt  <= '0;
            load_tick <= 1'b1; // the 100th edge after reset raises the first tick
        end else begin
            tick_cnt  <= tick_cnt + 7'd1;
            load_tick <= 1'b0;
        end
    end

endmodule

// ==== word_loader/ctrl_word_ram.sv ====
`timescale 1ns/1ps

module ctrl_word_ram (
    input  logic                     clk_1023k,
    input  logic                     rst_n,
    input  gnss_sig_pkg::word_t      wr_data,
    input  logic                     wr_word,
    input  gnss_sig_pkg::word_addr_t word_raddr,
    output gnss_sig_pkg::word_t      word_rdata
);
    import gnss_sig_pkg::*;

    word_t      word_mem [2**$bits(word_addr_t)];
    word_addr_t word_wptr;

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            word_wptr <= '0;
        end else if (wr_word) begin
            word_wptr <= word_wptr + 8'd1; // wraps at 256 by width
        end
    end

    always_ff @(posedge clk_1023k) begin
        if (wr_word) begin
            word_mem[word_wptr] <= wr_data;
        end
        word_rdata <= word_mem[word_raddr];
    end

endmodule

// ==== word_loader/word_loader_fsm.sv ====
`timescale 1ns/1ps

module word_loader_fsm (
    input  logic                     clk_1023k,
    input  logic                     rst_n,
    input  logic                     load_tick,
    input  gnss_sig_pkg::word_t      word_rdata,
    output gnss_sig_pkg::word_addr_t word_raddr,
    output gnss_sig_pkg::word_t      fre_carrier,
    output gnss_sig_pkg::word_t      fre_code,
    output gnss_sig_pkg::word_t      pha_code,
    output gnss_sig_pkg::delay_t     code_delay
);
    import gnss_sig_pkg::*;

    loader_state_t state;
    logic          load_go;

    // the tick is held one clock so fre_carrier loads two clocks after the tick is sampled
    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            load_go <= 1'b0;
        end else begin
            load_go <= load_tick;
        end
    end

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            state       <= LD_IDLE;
            word_raddr  <= '0;
            fre_carrier <= '0;
            fre_code    <= '0;
            pha_code    <= '0;
            code_delay  <= '0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (load_go) begin
                        state      <= LD_CARRIER;
                        word_raddr <= word_raddr + 8'd1;
                    end
                end
                LD_CARRIER: begin
                    fre_carrier <= word_rdata;
                    word_raddr  <= word_raddr + 8'd1;
                    state       <= LD_CODE_FRE;
                end
                LD_CODE_FRE: begin
                    fre_code   <= word_rdata;
                    word_raddr <= word_raddr + 8'd1;
                    state      <= LD_CODE_PHA;
                end
                LD_CODE_PHA: begin
                    pha_code   <= word_rdata;
                    word_raddr <= word_raddr + 8'd1; // pointer ends on the next group
                    state      <= LD_DELAY;
                end
                LD_DELAY: begin
                    code_delay <= word_rdata[$bits(delay_t)-1:0]; // only the low chip count matters
                    state      <= LD_IDLE;
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

endmodule

// ==== chip_gen/code_chip_gen.sv ====
`timescale 1ns/1ps

module code_chip_gen (
    input  logic                 clk_1023k,
    input  logic                 rst_n,
    input  gnss_sig_pkg::word_t  wr_data,
    input  logic                 wr_code,
    input  gnss_sig_pkg::delay_t code_delay,
    output logic                 code_chip,
    output logic                 code_epoch
);
    import gnss_sig_pkg::*;

    word_t       code_mem [2**$bits(code_waddr_t)];
    code_waddr_t code_wptr;
    code_addr_t  chip_cnt;
    code_addr_t  chip_raddr;

    always_ff @(posedge clk_1023k) begin
        if (wr_code) begin
            code_mem[code_wptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            code_wptr <= '0;
            chip_cnt  <= 10'd1;
        end else begin
            if (wr_code) begin
                code_wptr <= code_wptr + 5'd1;
            end
            if (chip_cnt == CODE_LEN) begin
                chip_cnt <= 10'd1; // count never visits zero
            end else begin
                chip_cnt <= chip_cnt + 10'd1;
            end
        end
    end

    // the delayed chip index wraps back into the code period
    always_comb begin
        if (chip_cnt > code_delay) begin
            chip_raddr = chip_cnt - code_delay;
        end else begin
            chip_raddr = code_addr_t'(11'(chip_cnt) + 11'd1024 - 11'(code_delay));
        end
    end

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            code_chip  <= 1'b0;
            code_epoch <= 1'b0;
        end else begin
            code_chip  <= code_mem[chip_raddr[9:5]][chip_raddr[4:0]];
            code_epoch <= (chip_raddr == CODE_LEN); // lines up with the last chip of the period
        end
    end

endmodule

// ==== chip_gen/nav_msg_gen.sv ====
`timescale 1ns/1ps

module nav_msg_gen (
    input  logic                clk_1023k,
    input  logic                rst_n,
    input  gnss_sig_pkg::word_t wr_data,
    input  logic                wr_msg,
    input  logic                code_epoch,
    output logic                msg_bit
);
    import gnss_sig_pkg::*;

    word_t      msg_mem [MSG_WORDS];
    msg_waddr_t msg_wptr;
    epoch_cnt_t epoch_cnt;
    msg_addr_t  msg_addr;

    always_ff @(posedge clk_1023k) begin
        if (wr_msg) begin
            msg_mem[msg_wptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            msg_wptr <= '0;
        end else if (wr_msg) begin
            if (msg_wptr == msg_waddr_t'(MSG_WORDS - 1)) begin
                msg_wptr <= '0;
            end else begin
                msg_wptr <= msg_wptr + 4'd1;
            end
        end
    end

    // one message bit lasts twenty code periods
    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            epoch_cnt <= '0;
            msg_addr  <= '0;
        end else if (code_epoch) begin
            if (epoch_cnt == EPOCHS_PER_BIT - 5'd1) begin
                epoch_cnt <= '0;
                if (msg_addr == MSG_LAST) begin
                    msg_addr <= MSG_LOOP_START; // the preamble bits are not repeated
                end else begin
                    msg_addr <= msg_addr + 9'd1;
                end
            end else begin
                epoch_cnt <= epoch_cnt + 5'd1;
            end
        end
    end

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            msg_bit <= 1'b0;
        end else begin
            msg_bit <= msg_mem[msg_addr[8:5]][msg_addr[4:0]];
        end
    end

endmodule

// ==== source/gnss_sig_buf.sv ====
`timescale 1ns/1ps

module gnss_sig_buf (
    input  logic                clk_1023k,
    input  logic                rst_n,
    input  gnss_sig_pkg::word_t wr_data,
    input  logic                wr_code,
    input  logic                wr_msg,
    input  logic                wr_word,
    output logic                code_chip,
    output logic                code_epoch,
    output logic                msg_bit,
    output gnss_sig_pkg::word_t fre_carrier,
    output gnss_sig_pkg::word_t fre_code,
    output gnss_sig_pkg::word_t pha_code
);
    import gnss_sig_pkg::*;

    logic       load_tick;
    word_addr_t word_raddr;
    word_t      word_rdata;
    delay_t     code_delay;

    load_timer u_load_timer (
        .clk_1023k (clk_1023k),
        .rst_n     (rst_n),
        .load_tick (load_tick)
    );

    ctrl_word_ram u_ctrl_word_ram (
        .clk_1023k  (clk_1023k),
        .rst_n      (rst_n),
        .wr_data    (wr_data),
        .wr_word    (wr_word),
        .word_raddr (word_raddr),
        .word_rdata (word_rdata)
    );

    word_loader_fsm u_word_loader_fsm (
        .clk_1023k   (clk_1023k),
        .rst_n       (rst_n),
        .load_tick   (load_tick),
        .word_rdata  (word_rdata),
        .word_raddr  (word_raddr),
        .fre_carrier (fre_carrier),
        .fre_code    (fre_code),
        .pha_code    (pha_code),
        .code_delay  (code_delay)
    );

    code_chip_gen u_code_chip_gen (
        .clk_1023k  (clk_1023k),
        .rst_n      (rst_n),
        .wr_data    (wr_data),
        .wr_code    (wr_code),
        .code_delay (code_delay),
        .code_chip  (code_chip),
        .code_epoch (code_epoch)
    );

    nav_msg_gen u_nav_msg_gen (
        .clk_1023k  (clk_1023k),
        .rst_n      (rst_n),
        .wr_data    (wr_data),
        .wr_msg     (wr_msg),
        .code_epoch (code_epoch),
        .msg_bit    (msg_bit)
    );

endmodule

// ==== dv/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk_1023k,
    output logic rst_n
);
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_1023k = 1'b0;
        forever #4 clk_1023k = ~clk_1023k; // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_1023k);
        rst_n <= 1'b1;
    end

endmodule

// ==== dv/gnss_sig_buf_asserts.sv ====
`timescale 1ns/1ps

module gnss_sig_buf_asserts (
    input logic                clk_1023k,
    input logic                rst_n,
    input gnss_sig_pkg::word_t wr_data,
    input logic                wr_code,
    input logic                wr_msg,
    input logic                wr_word,
    input logic                code_chip,
    input logic                code_epoch,
    input logic                msg_bit,
    input gnss_sig_pkg::word_t fre_carrier,
    input gnss_sig_pkg::word_t fre_code,
    input gnss_sig_pkg::word_t pha_code
);
    import gnss_sig_pkg::*;

    localparam int ALL_WRITES = 32 + MSG_WORDS + 256;

    word_t       code_sh [32];
    word_t       msg_sh [MSG_WORDS];
    word_t       word_sh [256];
    code_waddr_t code_wp;
    msg_waddr_t  msg_wp;
    word_addr_t  word_wp;
    int          wr_total;
    logic [6:0]  tick_cnt;
    logic        tick;
    logic [4:0]  ld_pipe;    // bit n set means a tick was sampled n clocks ago
    word_addr_t  m_ptr;
    delay_t      m_delay;
    code_addr_t  m_cnt;
    code_addr_t  chip_addr;
    epoch_cnt_t  epoch_cnt;
    msg_addr_t   m_maddr;
    logic        exp_chip;
    logic        exp_epoch;
    logic        exp_msg;
    word_t       exp_carrier;
    word_t       exp_fcode;
    word_t       exp_pcode;
    logic        first_load;
    logic        fresh_load;
    logic        armed;
    int          err_cnt = 0;

    function automatic code_addr_t delayed_addr(input code_addr_t cnt, input delay_t dly);
        int a;
        a = int'(cnt) - int'(dly);
        if (a <= 0) begin
            a = a + 1024;
        end
        return code_addr_t'(a); // 1024 lands on chip 0
    endfunction

    assign chip_addr = delayed_addr(m_cnt, m_delay);

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            code_wp  <= '0;
            msg_wp   <= '0;
            word_wp  <= '0;
            wr_total <= 0;
        end else begin
            if (wr_code) begin
                code_sh[code_wp] <= wr_data;
                code_wp          <= code_wp + 5'd1;
            end
            if (wr_msg) begin
                msg_sh[msg_wp] <= wr_data;
                msg_wp         <= (msg_wp == 4'd9) ? 4'd0 : msg_wp + 4'd1;
            end
            if (wr_word) begin
                word_sh[word_wp] <= wr_data;
                word_wp          <= word_wp + 8'd1;
            end
            if (wr_code || wr_msg || wr_word) begin
                wr_total <= wr_total + 1;
            end
        end
    end

    always_ff @(posedge clk_1023k or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt    <= '0;
            tick        <= 1'b0;
            ld_pipe     <= '0;
            m_ptr       <= '0;
            m_delay     <= '0;
            m_cnt       <= 10'd1;
            epoch_cnt   <= '0;
            m_maddr     <= '0;
            exp_chip    <= 1'b0;
            exp_epoch   <= 1'b0;
            exp_msg     <= 1'b0;
            exp_carrier <= '0;
            exp_fcode   <= '0;
            exp_pcode   <= '0;
            first_load  <= 1'b0;
            fresh_load  <= 1'b0;
            armed       <= 1'b0;
        end else begin
            tick_cnt <= (tick_cnt == 7'(LOAD_PERIOD - 1)) ? 7'd0 : tick_cnt + 7'd1;
            tick     <= (tick_cnt == 7'(LOAD_PERIOD - 1));
            ld_pipe  <= {ld_pipe[3:0], tick};
            if (ld_pipe[1]) begin
                exp_carrier <= word_sh[m_ptr];
            end
            if (ld_pipe[2]) begin
                exp_fcode <= word_sh[m_ptr + 8'd1];
            end
            if (ld_pipe[3]) begin
                exp_pcode <= word_sh[m_ptr + 8'd2];
            end
            if (ld_pipe[4]) begin
                m_delay <= delay_t'(word_sh[m_ptr + 8'd3]);
                m_ptr   <= m_ptr + 8'(WORDS_PER_LOAD);
            end
            m_cnt     <= (m_cnt == CODE_LEN) ? 10'd1 : m_cnt + 10'd1;
            exp_chip  <= code_sh[chip_addr[9:5]][chip_addr[4:0]];
            exp_epoch <= (chip_addr == CODE_LEN);
            if (exp_epoch) begin
                if (epoch_cnt == EPOCHS_PER_BIT - 5'd1) begin
                    epoch_cnt <= '0;
                    m_maddr   <= (m_maddr == MSG_LAST) ? MSG_LOOP_START : m_maddr + 9'd1;
                end else begin
                    epoch_cnt <= epoch_cnt + 5'd1;
                end
            end
            exp_msg    <= msg_sh[m_maddr[8:5]][m_maddr[4:0]];
            first_load <= first_load | ld_pipe[1];
            fresh_load <= fresh_load | (tick && wr_total == ALL_WRITES); // load after all writes
            armed      <= armed | (fresh_load && ld_pipe[4]);
        end
    end

    quiet_after_reset: assert property (@(posedge clk_1023k) disable iff (!rst_n)
        !first_load |-> (!code_epoch && fre_carrier == '0 && fre_code == '0 && pha_code == '0))
        else begin
            $error("Fail reset values code_epoch %h fre_carrier %h fre_code %h pha_code %h",
                code_epoch, fre_carrier, fre_code, pha_code);
            err_cnt = err_cnt + 1;
        end

    params_match: assert property (@(posedge clk_1023k) disable iff (!rst_n)
        armed |-> (fre_carrier == exp_carrier && fre_code == exp_fcode && pha_code == exp_pcode))
        else begin
            $error("Fail fre_carrier %h/%h fre_code %h/%h pha_code %h/%h (got/expected)",
                fre_carrier, exp_carrier, fre_code, exp_fcode, pha_code, exp_pcode);
            err_cnt = err_cnt + 1;
        end

    chip_match: assert property (@(posedge clk_1023k) disable iff (!rst_n)
        armed |-> code_chip == exp_chip)
        else begin
            $error("Fail code_chip got %h expected %h", code_chip, exp_chip);
            err_cnt = err_cnt + 1;
        end

    epoch_match: assert property (@(posedge clk_1023k) disable iff (!rst_n)
        armed |-> code_epoch == exp_epoch)
        else begin
            $error("Fail code_epoch got %h expected %h", code_epoch, exp_epoch);
            err_cnt = err_cnt + 1;
        end

    msg_match: assert property (@(posedge clk_1023k) disable iff (!rst_n)
        armed |-> msg_bit == exp_msg)
        else begin
            $error("Fail msg_bit got %h expected %h at bit %h", msg_bit, exp_msg, m_maddr);
            err_cnt = err_cnt + 1;
        end

endmodule

// ==== dv/tb_gnss_sig_buf.sv ====
`timescale 1ns/1ps

module tb_gnss_sig_buf;
    import gnss_sig_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int ARM_TIMEOUT   = 1000;
    localparam int EPOCH_TIMEOUT = 20000; // delay reloads can move the epoch by a period
    localparam int RUN_EPOCHS    = 25 * 20;

    logic   clk_1023k;
    logic   rst_n;
    word_t  wr_data;
    logic   wr_code;
    logic   wr_msg;
    logic   wr_word;
    logic   code_chip;
    logic   code_epoch;
    logic   msg_bit;
    word_t  fre_carrier;
    word_t  fre_code;
    word_t  pha_code;
    integer seed = 32'h61c2_8d4c;

    clk_rst_gen u_clk_rst_gen (
        .clk_1023k (clk_1023k),
        .rst_n     (rst_n)
    );

    gnss_sig_buf u_gnss_sig_buf (.*);

    bind gnss_sig_buf gnss_sig_buf_asserts u_asserts (.*);

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    // strobes are {wr_code, wr_msg, wr_word}
    task automatic write_block(input int count, input logic [2:0] strobes);
        for (int i = 0; i < count; i++) begin
            @(posedge clk_1023k);
            wr_data <= $random(seed);
            {wr_code, wr_msg, wr_word} <= strobes;
        end
        @(posedge clk_1023k);
        {wr_code, wr_msg, wr_word} <= 3'b000;
    endtask

    task automatic wait_reset_release();
        int cycles = 0;
        while (!rst_n) begin
            @(negedge clk_1023k);
            cycles++;
            if (cycles > RESET_TIMEOUT) report_failure("reset was never released");
        end
    endtask

    task automatic wait_checks_armed();
        int cycles = 0;
        while (!u_gnss_sig_buf.u_asserts.armed) begin
            @(negedge clk_1023k);
            cycles++;
            if (cycles > ARM_TIMEOUT) report_failure("no parameter load after the writes");
        end
    endtask

    task automatic wait_epochs(input int count);
        int cycles;
        for (int i = 0; i < count; i++) begin
            cycles = 0;
            do begin
                @(negedge clk_1023k);
                cycles++;
                if (cycles > EPOCH_TIMEOUT) report_failure("code epoch did not arrive");
            end while (!code_epoch);
        end
    endtask

    always @(posedge clk_1023k) begin
        if (u_gnss_sig_buf.u_asserts.err_cnt != 0) begin
            report_failure("an assertion failed");
        end
    end

    initial begin
        wr_data <= '0;
        wr_code <= 1'b0;
        wr_msg  <= 1'b0;
        wr_word <= 1'b0;
        wait_reset_release();
        write_block(32, 3'b100);
        write_block(MSG_WORDS, 3'b010);
        write_block(256, 3'b001);
        wait_checks_armed();
        wait_epochs(RUN_EPOCHS); // about 25 message bits
        @(negedge clk_1023k);
        if (u_gnss_sig_buf.u_asserts.err_cnt != 0) begin
            report_failure("assertion errors were raised");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== gnss_sig_buf.f ====
common/gnss_sig_pkg.sv
source/load_timer.sv
word_loader/ctrl_word_ram.sv
word_loader/word_loader_fsm.sv
chip_gen/code_chip_gen.sv
chip_gen/nav_msg_gen.sv
source/gnss_sig_buf.sv
dv/clk_rst_gen.sv
dv/gnss_sig_buf_asserts.sv
dv/tb_gnss_sig_buf.sv

// ==== build.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_gnss_sig_buf \
    -f gnss_sig_buf.f -o tb_gnss_sig_buf
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_gnss_sig_buf +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi
exit 0
